/* design/ex_defines.svh */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// ########################################
// datapath
// ########################################
`define XLEN 32 // data and address width.

// ########################################
// data ram
// ########################################
`define RAM_DEPTH 256 // number of 32-bit words.
`define RAM_AW    8   // word address width.

`endif

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

  // ########################################
  // alu opcodes
  // ########################################
  typedef enum logic [4:0] {
    ADD   = 5'd0,
    SUB   = 5'd1,
    XOR   = 5'd2,
    OR    = 5'd3,
    AND   = 5'd4,
    SLL   = 5'd5,
    SRL   = 5'd6,
    SRA   = 5'd7,
    SLT   = 5'd8,  // also slti, imm arrives as operand2.
    SLTU  = 5'd9,  // also sltiu.
    JUMP  = 5'd10,
    CSRRW = 5'd11,
    CSRRS = 5'd12,
    MUL   = 5'd13,
    DIV   = 5'd14,
    DIVU  = 5'd15,
    REM   = 5'd16,
    REMU  = 5'd17,
    LB    = 5'd18,
    LH    = 5'd19,
    LW    = 5'd20,
    LBU   = 5'd21,
    LHU   = 5'd22,
    SB    = 5'd23,
    SH    = 5'd24,
    SW    = 5'd25,
    NOP   = 5'd26
  } alu_op_e;

  // memory access width.
  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } acc_size_e;

endpackage

/* design/ex_pipe_pkg.sv */
`include "ex_defines.svh"

package ex_pipe_pkg;

  // ########################################
  // issue to execute
  // ########################################
  typedef struct packed {
    rv_isa_pkg::alu_op_e alu_op;
    logic [`XLEN-1:0]    operand1;
    logic [`XLEN-1:0]    operand2; // rs2 or immediate.
  } ex_req_t;

  // ########################################
  // address unit to memory stage
  // ########################################
  typedef struct packed {
    logic                  rd_en;
    logic                  wr_en;
    logic [`XLEN-1:0]      addr;
    logic [1:0]            offset;     // byte within the word.
    logic [3:0]            mask;       // one bit per byte lane.
    rv_isa_pkg::acc_size_e size;
    logic                  misaligned;
  } mem_req_t;

  // ########################################
  // write-back response
  // ########################################
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] data;
    logic             misaligned;
  } wb_rsp_t;

endpackage

/* design/exec_alu.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module exec_alu (
  input  ex_pipe_pkg::ex_req_t req_i,
  output logic [`XLEN-1:0]     result_o
);

  localparam logic [`XLEN-1:0] INST_LEN = 4;
  localparam logic [`XLEN-1:0] MIN_INT  = {1'b1, {(`XLEN-1){1'b0}}};
  localparam logic [`XLEN-1:0] ONE      = 1;

  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic [`XLEN:0]   diff; // msb is the borrow.
  logic             div_zero;
  logic             div_ovf;
  logic [`XLEN-1:0] div_s;
  logic [`XLEN-1:0] div_u;
  logic [`XLEN-1:0] quo_s;
  logic [`XLEN-1:0] rem_s;
  logic [`XLEN-1:0] quo_u;
  logic [`XLEN-1:0] rem_u;
  logic [`XLEN-1:0] result;

  assign op1  = req_i.operand1;
  assign op2  = req_i.operand2;
  assign diff = {1'b0, op1} - {1'b0, op2};

  // ########################################
  // divider
  // ########################################
  assign div_zero = (op2 == '0);
  assign div_ovf  = (op1 == MIN_INT) && (op2 == '1);

  // overflow divides by one, which yields the dividend and a zero remainder.
  assign div_s = (div_zero || div_ovf) ? ONE : op2;
  assign div_u = div_zero ? ONE : op2;

  assign quo_s = $signed(op1) / $signed(div_s);
  assign rem_s = $signed(op1) % $signed(div_s);
  assign quo_u = op1 / div_u;
  assign rem_u = op1 % div_u;

  always_comb begin
    case (req_i.alu_op)
      rv_isa_pkg::ADD:   result = op1 + op2;
      rv_isa_pkg::SUB:   result = diff[`XLEN-1:0];
      rv_isa_pkg::XOR:   result = op1 ^ op2;
      rv_isa_pkg::OR:    result = op1 | op2;
      rv_isa_pkg::AND:   result = op1 & op2;
      rv_isa_pkg::SLL:   result = op1 << op2[4:0];
      rv_isa_pkg::SRL:   result = op1 >> op2[4:0];
      rv_isa_pkg::SRA:   result = $signed(op1) >>> op2[4:0];
      rv_isa_pkg::SLT:   result = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      rv_isa_pkg::SLTU:  result = {{(`XLEN-1){1'b0}}, diff[`XLEN]};
      rv_isa_pkg::JUMP:  result = INST_LEN + op2; // link address.
      rv_isa_pkg::CSRRW: result = op1;
      rv_isa_pkg::CSRRS: result = op1;
      rv_isa_pkg::MUL:   result = op1 * op2;   // low half of the product.
      rv_isa_pkg::DIV:   result = div_zero ? '1 : quo_s;
      rv_isa_pkg::DIVU:  result = div_zero ? '1 : quo_u;
      rv_isa_pkg::REM:   result = div_zero ? op1 : rem_s;
      rv_isa_pkg::REMU:  result = div_zero ? op1 : rem_u;
      default:           result = '0;          // loads, stores and nop.
    endcase
    if (!$isunknown(req_i)) begin
      assert (!$isunknown(result))
        else $error("exec_alu: unknown result for opcode %0d.", req_i.alu_op);
    end
  end

  assign result_o = result;

endmodule

/* design/exec_agu.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module exec_agu (
  input  logic                  valid_i,
  input  ex_pipe_pkg::ex_req_t  req_i,
  output ex_pipe_pkg::mem_req_t mem_req_o
);

  logic                  is_load;
  logic                  is_store;
  logic [3:0]            base_mask;
  logic                  bad_align;
  ex_pipe_pkg::mem_req_t mem_req;

  // opcode class and access width.
  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    mem_req.size = rv_isa_pkg::WORD;
    case (req_i.alu_op)
      rv_isa_pkg::LB, rv_isa_pkg::LBU: begin
        is_load      = 1'b1;
        mem_req.size = rv_isa_pkg::BYTE;
      end
      rv_isa_pkg::LH, rv_isa_pkg::LHU: begin
        is_load      = 1'b1;
        mem_req.size = rv_isa_pkg::HALF;
      end
      rv_isa_pkg::LW: is_load = 1'b1;
      rv_isa_pkg::SB: begin
        is_store     = 1'b1;
        mem_req.size = rv_isa_pkg::BYTE;
      end
      rv_isa_pkg::SH: begin
        is_store     = 1'b1;
        mem_req.size = rv_isa_pkg::HALF;
      end
      rv_isa_pkg::SW: is_store = 1'b1;
      default: ;
    endcase

    mem_req.addr   = (is_load || is_store) ? req_i.operand1 + req_i.operand2 : '0;
    mem_req.offset = mem_req.addr[1:0];

    case (mem_req.size)
      rv_isa_pkg::BYTE: begin
        base_mask = 4'b0001;
        bad_align = 1'b0;
      end
      rv_isa_pkg::HALF: begin
        base_mask = 4'b0011;
        bad_align = (mem_req.offset == 2'd3); // half-word crosses the word.
      end
      default: begin
        base_mask = 4'b1111;
        bad_align = (mem_req.offset != 2'd0);
      end
    endcase

    mem_req.misaligned = (is_load || is_store) && bad_align;
    mem_req.rd_en      = valid_i && is_load && !mem_req.misaligned;
    mem_req.wr_en      = valid_i && is_store && !mem_req.misaligned;
    mem_req.mask       = mem_req.wr_en ? (base_mask << mem_req.offset) : 4'b0000;

    assert (!(mem_req.rd_en && mem_req.wr_en))
      else $error("exec_agu: read and write enabled together.");
  end

  assign mem_req_o = mem_req;

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module mem_stage (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  rv_isa_pkg::alu_op_e   alu_op_i,
  input  logic [`XLEN-1:0]      alu_result_i,
  input  ex_pipe_pkg::mem_req_t mem_req_i,
  input  logic [`XLEN-1:0]      wdata_i,
  output logic                  valid_o,
  output rv_isa_pkg::alu_op_e   alu_op_o,
  output logic [`XLEN-1:0]      alu_result_o,
  output logic [`XLEN-1:0]      rdata_o,
  output logic [1:0]            offset_o,
  output rv_isa_pkg::acc_size_e size_o,
  output logic                  misaligned_o
);

  localparam int NB = `XLEN / 8;

  logic [`XLEN-1:0]   ram_q [`RAM_DEPTH];
  logic [`RAM_AW-1:0] word_addr;
  logic [`XLEN-1:0]   wdata_sh;

  assign word_addr = mem_req_i.addr[`RAM_AW+1:2];
  assign wdata_sh  = wdata_i << {mem_req_i.offset, 3'b000}; // align data to its lanes.

  // ########################################
  // stage register
  // ########################################
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o      <= 1'b0;
      alu_op_o     <= rv_isa_pkg::NOP;
      misaligned_o <= 1'b0;
    end else begin
      valid_o      <= valid_i;
      alu_op_o     <= alu_op_i;
      misaligned_o <= valid_i && mem_req_i.misaligned;
    end
  end

  always_ff @(posedge clk_i) begin
    alu_result_o <= alu_result_i;
    offset_o     <= mem_req_i.offset;
    size_o       <= mem_req_i.size;
  end

  // ########################################
  // data ram
  // ########################################
  always_ff @(posedge clk_i) begin
    if (mem_req_i.wr_en) begin
      for (int b = 0; b < NB; b++) begin
        if (mem_req_i.mask[b]) begin
          ram_q[word_addr][8*b +: 8] <= wdata_sh[8*b +: 8];
        end
      end
    end
    if (mem_req_i.rd_en) begin
      rdata_o <= ram_q[word_addr];
    end
  end

  // lanes may only be written by an aligned, valid store.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (|mem_req_i.mask) |-> mem_req_i.wr_en)
    else $error("mem_stage: byte mask set without write enable.");

endmodule

/* design/load_extend.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module load_extend (
  input  logic                  valid_i,
  input  rv_isa_pkg::alu_op_e   alu_op_i,
  input  logic [`XLEN-1:0]      alu_result_i,
  input  logic [`XLEN-1:0]      rdata_i,
  input  logic [1:0]            offset_i,
  input  rv_isa_pkg::acc_size_e size_i,
  input  logic                  misaligned_i,
  output ex_pipe_pkg::wb_rsp_t  wb_o
);

  logic [`XLEN-1:0] shifted;
  logic [`XLEN-1:0] load_data;
  logic             is_load;
  logic             is_store;
  logic             sign_ext;

  assign shifted = rdata_i >> {offset_i, 3'b000}; // addressed byte to lane 0.

  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    sign_ext = 1'b0;
    case (alu_op_i)
      rv_isa_pkg::LB, rv_isa_pkg::LH: begin
        is_load  = 1'b1;
        sign_ext = 1'b1;
      end
      rv_isa_pkg::LW, rv_isa_pkg::LBU, rv_isa_pkg::LHU: is_load = 1'b1;
      rv_isa_pkg::SB, rv_isa_pkg::SH, rv_isa_pkg::SW: is_store = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    case (size_i)
      rv_isa_pkg::BYTE: load_data = {{(`XLEN-8){sign_ext & shifted[7]}}, shifted[7:0]};
      rv_isa_pkg::HALF: load_data = {{(`XLEN-16){sign_ext & shifted[15]}}, shifted[15:0]};
      default:          load_data = shifted;
    endcase
  end

  always_comb begin
    wb_o.valid      = valid_i;
    wb_o.misaligned = misaligned_i;
    if (misaligned_i || is_store) begin
      wb_o.data = '0;
    end else if (is_load) begin
      wb_o.data = load_data;
    end else begin
      wb_o.data = alu_result_i;
    end
  end

endmodule

/* design/ex_mem_top.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_mem_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 valid_i,
  input  ex_pipe_pkg::ex_req_t req_i,
  input  logic [`XLEN-1:0]     wdata_i,
  output ex_pipe_pkg::wb_rsp_t wb_o
);

  logic [`XLEN-1:0]      alu_result;
  ex_pipe_pkg::mem_req_t mem_req;

  // registered by the memory stage.
  logic                  ms_valid;
  rv_isa_pkg::alu_op_e   ms_alu_op;
  logic [`XLEN-1:0]      ms_alu_result;
  logic [`XLEN-1:0]      ms_rdata;
  logic [1:0]            ms_offset;
  rv_isa_pkg::acc_size_e ms_size;
  logic                  ms_misaligned;

  exec_alu u_alu (
    .req_i    (req_i),
    .result_o (alu_result)
  );

  exec_agu u_agu (
    .valid_i   (valid_i),
    .req_i     (req_i),
    .mem_req_o (mem_req)
  );

  mem_stage u_mem (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .valid_i      (valid_i),
    .alu_op_i     (req_i.alu_op),
    .alu_result_i (alu_result),
    .mem_req_i    (mem_req),
    .wdata_i      (wdata_i),
    .valid_o      (ms_valid),
    .alu_op_o     (ms_alu_op),
    .alu_result_o (ms_alu_result),
    .rdata_o      (ms_rdata),
    .offset_o     (ms_offset),
    .size_o       (ms_size),
    .misaligned_o (ms_misaligned)
  );

  load_extend u_ext (
    .valid_i      (ms_valid),
    .alu_op_i     (ms_alu_op),
    .alu_result_i (ms_alu_result),
    .rdata_i      (ms_rdata),
    .offset_i     (ms_offset),
    .size_i       (ms_size),
    .misaligned_i (ms_misaligned),
    .wb_o         (wb_o)
  );

endmodule

/* verification/tb_ex_mem.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module tb_ex_mem;

  localparam time CLK_PERIOD = 100ns;

  // one line of the stimulus file.
  typedef struct packed {
    logic                 rand_ops;
    ex_pipe_pkg::ex_req_t req;
    logic [`XLEN-1:0]     wdata;
    logic [`XLEN-1:0]     exp_data;
    logic                 exp_flag;
  } stim_t;

  // one outstanding write-back.
  typedef struct packed {
    rv_isa_pkg::alu_op_e op;
    logic [31:0]         index;
    logic [31:0]         cycle;  // issue cycle.
    logic [`XLEN-1:0]    data;
    logic                flag;
  } expect_t;

  logic                 clk;
  logic                 arst_n;
  logic                 valid;
  ex_pipe_pkg::ex_req_t req;
  logic [`XLEN-1:0]     wdata;
  ex_pipe_pkg::wb_rsp_t wb;

  stim_t   stim_q[$];
  expect_t exp_q[$];
  int      cycle_cnt = 0;
  int      n_lines = 0;

  ex_mem_top dut0 (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .valid_i  (valid),
    .req_i    (req),
    .wdata_i  (wdata),
    .wb_o     (wb)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ########################################
  // reporting and checks
  // ########################################
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input expect_t e, input logic [`XLEN-1:0] got);
    if (got !== e.data) begin
      fail_run($sformatf("error %0t: stimulus %0d (%s) data %h, expected %h",
                         $time, e.index, e.op.name(), got, e.data));
    end
  endtask

  task automatic check_flag(input expect_t e, input logic got);
    if (got !== e.flag) begin
      fail_run($sformatf("error %0t: stimulus %0d (%s) misaligned %b, expected %b",
                         $time, e.index, e.op.name(), got, e.flag));
    end
  endtask

  // expected result of a register-style operation.
  function automatic logic [`XLEN-1:0] model_alu(input rv_isa_pkg::alu_op_e op,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      rv_isa_pkg::ADD:  return a + b;
      rv_isa_pkg::SUB:  return a - b;
      rv_isa_pkg::XOR:  return a ^ b;
      rv_isa_pkg::OR:   return a | b;
      rv_isa_pkg::AND:  return a & b;
      rv_isa_pkg::SLL:  return a << sh;
      rv_isa_pkg::SRL:  return a >> sh;
      rv_isa_pkg::SRA:  return $signed(a) >>> sh;
      rv_isa_pkg::SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
      rv_isa_pkg::SLTU: return (a < b) ? 1 : 0;
      default: return '0;
    endcase
  endfunction

  // ########################################
  // driver and monitor
  // ########################################
  task automatic drive_one(input stim_t s, input int idx);
    expect_t e;
    if (s.rand_ops) begin
      s.req.operand1 = $urandom();
      s.req.operand2 = $urandom();
      s.exp_data     = model_alu(s.req.alu_op, s.req.operand1, s.req.operand2);
      s.exp_flag     = 1'b0;
    end
    valid   = 1'b1;
    req     = s.req;
    wdata   = s.wdata;
    e.op    = s.req.alu_op;
    e.index = idx;
    e.cycle = cycle_cnt;
    e.data  = s.exp_data;
    e.flag  = s.exp_flag;
    exp_q.push_back(e);
  endtask

  // wb_o is registered, so it is stable at the falling edge.
  always @(negedge clk) begin
    if (exp_q.size() != 0 && exp_q[0].cycle + 1 == cycle_cnt) begin
      if (wb.valid !== 1'b1) begin
        fail_run($sformatf("no write-back pulse for stimulus %0d", exp_q[0].index));
      end
      check_data(exp_q[0], wb.data);
      check_flag(exp_q[0], wb.misaligned);
      void'(exp_q.pop_front());
    end else if (wb.valid !== 1'b0) begin
      fail_run("write-back pulse without an issued instruction");
    end
  end

  initial begin
    wait (n_lines > 0);
    #((n_lines + 20) * CLK_PERIOD);
    fail_run("timeout, the run did not finish in time");
  end

  initial begin
    int    fd;
    int    code;
    int    op;
    int    flag;
    byte   kind;
    string line;
    stim_t s;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] w;
    logic [`XLEN-1:0] d;
    clk    = 1'b0;
    arst_n = 1'b0;
    valid  = 1'b0;
    req    = '0;
    wdata  = '0;
    void'($urandom(82136));

    fd = $fopen("verification/ex_mem_stim.txt", "r");
    if (fd == 0) fail_run("cannot open verification/ex_mem_stim.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 3 || line.substr(0, 1) == "//") continue;
      code = $sscanf(line, "%c %d %h %h %h %h %d", kind, op, a, b, w, d, flag);
      if (code != 7) fail_run({"malformed stimulus line: ", line});
      s.rand_ops     = (kind == "r");
      s.req.alu_op   = rv_isa_pkg::alu_op_e'(op[4:0]);
      s.req.operand1 = a;
      s.req.operand2 = b;
      s.wdata        = w;
      s.exp_data     = d;
      s.exp_flag     = flag[0];
      stim_q.push_back(s);
    end
    $fclose(fd);
    if (stim_q.size() == 0) fail_run("the stimulus file holds no instructions");
    n_lines = stim_q.size();

    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    foreach (stim_q[i]) begin
      @(negedge clk);
      drive_one(stim_q[i], i);
    end
    @(negedge clk);
    valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk); // catches a stray pulse.
    $display("All tests passed");
    $finish;
  end

endmodule

/* verification/ex_mem_stim.txt */
// kind (d directed, r random) opcode(dec) operand1 operand2 store_data expected misaligned
// random lines take both operands from the testbench, the other columns are ignored
d 0 7fffffff 00000001 00000000 80000000 0
d 1 80000000 00000001 00000000 7fffffff 0
d 7 80000000 0000003f 00000000 ffffffff 0
d 8 ffffffff 00000001 00000000 00000001 0
d 9 ffffffff 00000001 00000000 00000000 0
d 9 00000001 ffffffff 00000000 00000001 0
r 0 0 0 0 0 0
r 1 0 0 0 0 0
r 2 0 0 0 0 0
r 3 0 0 0 0 0
r 4 0 0 0 0 0
r 5 0 0 0 0 0
r 6 0 0 0 0 0
r 7 0 0 0 0 0
r 8 0 0 0 0 0
r 9 0 0 0 0 0
d 13 ffffffff ffffffff 00000000 00000001 0
d 14 80000000 ffffffff 00000000 80000000 0
d 16 80000000 ffffffff 00000000 00000000 0
d 14 fffffff9 00000002 00000000 fffffffd 0
d 14 fffffff9 00000000 00000000 ffffffff 0
d 16 fffffff9 00000000 00000000 fffffff9 0
d 15 ffffffff 00000002 00000000 7fffffff 0
d 15 00000007 00000000 00000000 ffffffff 0
d 17 00000007 00000000 00000000 00000007 0
d 10 00000000 00000100 00000000 00000104 0
d 11 12345678 00000000 00000000 12345678 0
d 12 9abcdef0 00000001 00000000 9abcdef0 0
d 25 00000040 00000000 11223344 00000000 0
d 23 00000040 00000001 ffffffaa 00000000 0
d 23 00000040 00000003 000000bb 00000000 0
d 24 00000040 00000001 1234cccc 00000000 0
d 23 00000040 00000000 00000055 00000000 0
d 23 00000040 00000002 00000066 00000000 0
d 24 00000040 00000002 00007788 00000000 0
d 20 00000040 00000000 00000000 7788cc55 0
d 18 00000041 00000000 00000000 ffffffcc 0
d 21 00000040 00000001 00000000 000000cc 0
d 18 00000040 00000003 00000000 00000077 0
d 21 00000040 00000000 00000000 00000055 0
d 19 00000040 00000000 00000000 ffffcc55 0
d 22 00000040 00000000 00000000 0000cc55 0
d 19 00000040 00000002 00000000 00007788 0
d 19 00000040 00000001 00000000 ffff88cc 0
d 22 00000040 00000001 00000000 000088cc 0
d 24 00000040 00000003 ffffffff 00000000 1
d 25 00000040 00000002 ffffffff 00000000 1
d 20 00000040 00000000 00000000 7788cc55 0
d 20 00000040 00000001 00000000 00000000 1
d 19 00000040 00000003 00000000 00000000 1

/* filelist.f */
+incdir+design
design/rv_isa_pkg.sv
design/ex_pipe_pkg.sv
design/exec_alu.sv
design/exec_agu.sv
design/mem_stage.sv
design/load_extend.sv
design/ex_mem_top.sv
verification/tb_ex_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex_mem
RTL_TOP   ?= ex_mem_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass message.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
